//--- sram_axi.f
verilog/axi_pkg.sv
verilog/sram_pkg.sv
verilog/sram_macro.sv
verilog/sram_wrapper.sv
verilog/axi_sram_ctrl.sv
verilog/sram_axi_top.sv
tb/tb_clk_gen.sv
tb/sram_axi_tb.sv

//--- tb/sram_axi_tb.sv
`timescale 1ns/1ps

module sram_axi_tb
  import axi_pkg::*;
  import sram_pkg::*;
();

  localparam int timeout_cyc = 50;

  logic                  clk;
  logic                  rst_n;
  logic [axi_addr_w-1:0] awaddr;
  logic [axi_addr_w-1:0] araddr;
  logic [axi_data_w-1:0] wdata;
  logic [axi_data_w-1:0] rdata;
  logic [axi_strb_w-1:0] wstrb;
  logic [axi_resp_w-1:0] bresp;
  logic [axi_resp_w-1:0] rresp;
  logic                  awvalid;
  logic                  awready;
  logic                  wvalid;
  logic                  wready;
  logic                  bvalid;
  logic                  bready;
  logic                  arvalid;
  logic                  arready;
  logic                  rvalid;
  logic                  rready;

  logic [sram_data_w-1:0] ref_mem [sram_depth];  // expected macro contents
  logic [axi_addr_w-1:0]  addr_q [$];
  logic                   last_wr_model = 1'b0;
  integer                 seed;
  int                     errors;
  int                     test_base;
  int                     pass_cnt;
  int                     fail_cnt;
  int                     cycle;
  int                     aw_cycle;
  int                     ar_cycle;

  tb_clk_gen tb_clk_gen_i (.clk(clk), .rst_n(rst_n));

  sram_axi_top sram_axi_top_i (.*);

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
                           bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("bvalid dropped or bresp changed while bready was low");
      errors++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
                           rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("rvalid dropped or rdata/rresp changed while rready was low");
      errors++;
    end

  b_latency: assert property (@(posedge clk) disable iff (!rst_n)
                              $rose(bvalid) == $past(awvalid && awready && wvalid && wready))
    else begin
      $display("bvalid did not rise exactly one cycle after the AW/W transfer");
      errors++;
    end

  r_latency: assert property (@(posedge clk) disable iff (!rst_n)
                              $rose(rvalid) == $past(arvalid && arready, 2))
    else begin
      $display("rvalid did not rise exactly two cycles after the AR transfer");
      errors++;
    end

  busy_no_accept: assert property (@(posedge clk) disable iff (!rst_n)
                                   (bvalid || rvalid) |-> !(awready || wready || arready))
    else begin
      $display("a request was accepted while a response was still pending");
      errors++;
    end

  function automatic void compare_value(string name, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("Error: %s expected %h got %h", name, exp, act);
      errors++;
    end
  endfunction

  function automatic logic [1:0] expected_resp(logic [31:0] addr);
    sram_addr_u a;
    a.raw = addr;
    return (a.f.region == '0) ? resp_okay : resp_decerr;
  endfunction

  function automatic logic [31:0] expected_read(logic [31:0] addr);
    sram_addr_u a;
    a.raw = addr;
    return (a.f.region == '0) ? ref_mem[a.f.index] : '0;  // decerr reads return zero
  endfunction

  function automatic void apply_write(logic [31:0] addr, logic [31:0] data, logic [3:0] strb);
    sram_addr_u a;
    a.raw = addr;
    for (int b = 0; b < 4; b++) begin
      if (strb[b] && a.f.region == '0) begin
        ref_mem[a.f.index][8*b +: 8] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic logic [31:0] random_addr();
    sram_addr_u a;
    a.raw = $random(seed);
    a.f.region = '0;
    a.f.offset = '0;
    return a.raw;
  endfunction

  // 0 aw and w, 1 b, 2 ar, 3 r
  function automatic logic chan_flag(int ch);
    case (ch)
      0: return awready && wready;
      1: return bvalid;
      2: return arready;
      default: return rvalid;
    endcase
  endfunction

  task automatic wait_for(input int ch, input string what);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!chan_flag(ch) && n < timeout_cyc);
    if (!chan_flag(ch)) begin
      $display("timeout: the %s handshake never completed", what);
      errors++;
    end
  endtask

  task automatic write_txn(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_for(0, "AW/W");
    @(posedge clk);
    #1;
    aw_cycle = cycle;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    bready = 1'b1;
    wait_for(1, "B");
    compare_value("bresp", expected_resp(addr), bresp);
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_txn(input logic [31:0] addr, input logic [31:0] exp_data, input int hold);
    araddr  = addr;
    arvalid = 1'b1;
    wait_for(2, "AR");
    @(posedge clk);
    #1;
    ar_cycle = cycle;
    arvalid  = 1'b0;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    rready = 1'b1;
    wait_for(3, "R");
    compare_value("rresp", expected_resp(addr), rresp);
    compare_value("rdata", exp_data, rdata);
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  // write and read raised together so the tie winner alternates
  task automatic run_pair(input logic [31:0] waddr, input logic [31:0] data,
                          input logic [3:0] strb, input logic [31:0] raddr,
                          input int whold, input int rhold);
    logic        wr_first;
    logic [31:0] exp_rd;
    wr_first = !last_wr_model;
    if (wr_first) apply_write(waddr, data, strb);
    exp_rd = expected_read(raddr);
    if (!wr_first) apply_write(waddr, data, strb);
    fork
      write_txn(waddr, data, strb, whold);
      read_txn(raddr, exp_rd, rhold);
    join
    last_wr_model = wr_first;
    compare_value("write_first", wr_first, aw_cycle < ar_cycle);
  endtask

  task automatic end_test(input string name);
    if (errors > test_base) begin
      fail_cnt++;
      $display("test %s: FAIL", name);
    end else begin
      pass_cnt++;
      $display("test %s: ok", name);
    end
    test_base = errors;
  endtask

  initial begin
    sram_addr_u  a;
    logic [31:0] d;
    logic [31:0] wd;
    logic [31:0] r;
    logic [3:0]  ws;
    int          n;
    int          h1;
    int          h2;
    seed    = 32'ha0717ee3;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;

    n = 0;
    while (!rst_n && n < timeout_cyc) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      errors++;
    end
    @(posedge clk);
    #1;
    compare_value("ready_valid", '0, {awready, wready, arready, bvalid, rvalid});
    d = random_addr();
    read_txn(d, expected_read(d), 0);  // unwritten word so only the response matters
    end_test("reset_state");

    for (int i = 0; i < 16; i++) begin
      d  = random_addr();
      wd = $random(seed);
      addr_q.push_back(d);
      apply_write(d, wd, 4'hf);
      write_txn(d, wd, 4'hf, 0);
    end
    foreach (addr_q[i]) read_txn(addr_q[i], expected_read(addr_q[i]), 0);
    end_test("full_word");

    for (int i = 0; i < 12; i++) begin
      wd = $random(seed);
      r  = $random(seed);
      ws = r[3:0];
      apply_write(addr_q[i], wd, ws);
      write_txn(addr_q[i], wd, ws, 0);
      read_txn(addr_q[i], expected_read(addr_q[i]), 0);
    end
    end_test("byte_strobe");

    for (int i = 0; i < 6; i++) begin
      a.raw      = addr_q[i];
      r          = $random(seed);
      a.f.region = r[sram_region_w-1:0] | 1'b1;  // alias outside the window
      wd         = $random(seed);
      apply_write(a.raw, wd, 4'hf);
      write_txn(a.raw, wd, 4'hf, 0);
      read_txn(a.raw, expected_read(a.raw), 0);
      read_txn(addr_q[i], expected_read(addr_q[i]), 0);
    end
    end_test("decode_error");

    for (int i = 0; i < 8; i++) begin
      wd = $random(seed);
      r  = $random(seed);
      ws = r[3:0];
      h1 = $random(seed) & 7;
      h2 = $random(seed) & 7;
      run_pair(addr_q[i], wd, ws, addr_q[i+8], h1, h2);
    end
    end_test("back_pressure");

    for (int i = 0; i < 8; i++) begin
      wd = $random(seed);
      r  = $random(seed);
      ws = r[3:0];
      run_pair(addr_q[i], wd, ws, addr_q[i], 0, 0);
    end
    end_test("simultaneous");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- verilog/axi_pkg.sv
package axi_pkg;

  // AXI4-Lite bus geometry
  localparam int axi_addr_w = 32;
  localparam int axi_data_w = 32;
  localparam int axi_strb_w = axi_data_w / 8;  // one strobe per byte
  localparam int axi_resp_w = 2;

  // response codes
  localparam logic [axi_resp_w-1:0] resp_okay   = 2'b00;
  localparam logic [axi_resp_w-1:0] resp_slverr = 2'b10;
  localparam logic [axi_resp_w-1:0] resp_decerr = 2'b11;

  // slave FSM encoding
  localparam int st_w = 2;

  localparam logic [st_w-1:0] st_idle       = 2'd0;
  localparam logic [st_w-1:0] st_write_resp = 2'd1;
  localparam logic [st_w-1:0] st_read_wait  = 2'd2;  // macro output not yet valid
  localparam logic [st_w-1:0] st_read_resp  = 2'd3;

endpackage

//--- verilog/axi_sram_ctrl.sv
`timescale 1ns/1ps

module axi_sram_ctrl
  import axi_pkg::*;
  import sram_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // write channels
  input  logic [axi_addr_w-1:0]  awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [axi_data_w-1:0]  wdata,
  input  logic [axi_strb_w-1:0]  wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [axi_resp_w-1:0]  bresp,
  output logic                   bvalid,
  input  logic                   bready,
  // read channels
  input  logic [axi_addr_w-1:0]  araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [axi_data_w-1:0]  rdata,
  output logic [axi_resp_w-1:0]  rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // macro side
  output logic [sram_addr_w-1:0] sram_addr,
  output logic [sram_data_w-1:0] sram_wdata,
  output logic [sram_be_w-1:0]   sram_web,
  input  logic [sram_data_w-1:0] sram_rdata
);

  logic [st_w-1:0] state;
  logic [st_w-1:0] state_nxt;
  logic            last_wr;  // write won the last conflict
  logic            wr_pend;
  logic            rd_pend;
  logic            grant_wr;
  logic            grant_rd;
  logic            aw_hit;
  logic            ar_hit;
  logic            rd_err_q;
  sram_addr_u      aw_dec;
  sram_addr_u      ar_dec;

  assign aw_dec.raw = awaddr;
  assign ar_dec.raw = araddr;
  assign aw_hit     = (aw_dec.f.region == '0);
  assign ar_hit     = (ar_dec.f.region == '0);

  // a write needs both AW and W before it can be taken
  assign wr_pend = awvalid && wvalid;
  assign rd_pend = arvalid;

  // on a tie the kind not served last wins
  assign grant_wr = (state == st_idle) && wr_pend && (!rd_pend || !last_wr);
  assign grant_rd = (state == st_idle) && rd_pend && !grant_wr;

  assign awready = grant_wr;
  assign wready  = grant_wr;
  assign arready = grant_rd;

  assign bvalid = (state == st_write_resp);
  assign rvalid = (state == st_read_resp);

  // the macro acts on the same edge as the AXI transfer
  assign sram_addr  = grant_wr ? aw_dec.f.index : ar_dec.f.index;
  assign sram_wdata = wdata;
  assign sram_web   = (grant_wr && aw_hit) ? ~wstrb : sram_web_off;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (grant_wr) begin
          state_nxt = st_write_resp;
        end else if (grant_rd) begin
          state_nxt = st_read_wait;
        end
      end
      st_write_resp: begin
        if (bready) begin
          state_nxt = st_idle;
        end
      end
      st_read_wait: begin
        state_nxt = st_read_resp;  // macro word shows up now
      end
      st_read_resp: begin
        if (rready) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      last_wr <= 1'b0;
    end else begin
      state <= state_nxt;
      // only a tie moves the priority
      if ((state == st_idle) && wr_pend && rd_pend) begin
        last_wr <= grant_wr;
      end
    end
  end

  // response payload held stable while valid waits
  always_ff @(posedge clk) begin
    if (grant_wr) begin
      bresp <= aw_hit ? resp_okay : resp_decerr;
    end
    if (grant_rd) begin
      rd_err_q <= !ar_hit;
    end
    if (state == st_read_wait) begin
      rdata <= rd_err_q ? '0 : sram_rdata;
      rresp <= rd_err_q ? resp_decerr : resp_okay;
    end
  end

endmodule

//--- verilog/sram_axi_top.sv
`timescale 1ns/1ps

module sram_axi_top
  import axi_pkg::*;
  import sram_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [axi_addr_w-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [axi_data_w-1:0] wdata,
  input  logic [axi_strb_w-1:0] wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic [axi_resp_w-1:0] bresp,
  output logic                  bvalid,
  input  logic                  bready,
  input  logic [axi_addr_w-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [axi_data_w-1:0] rdata,
  output logic [axi_resp_w-1:0] rresp,
  output logic                  rvalid,
  input  logic                  rready
);

  logic [sram_addr_w-1:0] sram_addr;
  logic [sram_data_w-1:0] sram_wdata;
  logic [sram_be_w-1:0]   sram_web;
  logic [sram_data_w-1:0] sram_rdata;

  axi_sram_ctrl axi_sram_ctrl_i (.*);  // all port names match

  sram_wrapper sram_wrapper_i (
    .clk   (clk       ),
    .addr  (sram_addr ),
    .wdata (sram_wdata),
    .web   (sram_web  ),
    .rdata (sram_rdata)
  );

endmodule

//--- verilog/sram_macro.sv
`timescale 1ns/1ps

module sram_macro
  import sram_pkg::*;
(
  input  logic ck,
  input  logic cs,
  input  logic oe,
  input  logic a0,
  input  logic a1,
  input  logic a2,
  input  logic a3,
  input  logic a4,
  input  logic a5,
  input  logic a6,
  input  logic a7,
  input  logic a8,
  input  logic a9,
  input  logic a10,
  input  logic a11,
  input  logic a12,
  input  logic a13,
  input  logic di0,  di1,  di2,  di3,  di4,  di5,  di6,  di7,
  input  logic di8,  di9,  di10, di11, di12, di13, di14, di15,
  input  logic di16, di17, di18, di19, di20, di21, di22, di23,
  input  logic di24, di25, di26, di27, di28, di29, di30, di31,
  input  logic web0,
  input  logic web1,
  input  logic web2,
  input  logic web3,
  output logic do0,  do1,  do2,  do3,  do4,  do5,  do6,  do7,
  output logic do8,  do9,  do10, do11, do12, do13, do14, do15,
  output logic do16, do17, do18, do19, do20, do21, do22, do23,
  output logic do24, do25, do26, do27, do28, do29, do30, do31
);

  logic [sram_addr_w-1:0] addr;
  logic [sram_data_w-1:0] din;
  logic [sram_data_w-1:0] dout;
  logic [sram_be_w-1:0]   web;

  logic [sram_data_w-1:0] mem [sram_depth];
  logic [sram_data_w-1:0] dout_q;

  // gather the pins back into words
  assign addr = {a13, a12, a11, a10, a9, a8, a7,
                 a6, a5, a4, a3, a2, a1, a0};

  assign din = {di31, di30, di29, di28, di27, di26, di25, di24,
                di23, di22, di21, di20, di19, di18, di17, di16,
                di15, di14, di13, di12, di11, di10, di9,  di8,
                di7,  di6,  di5,  di4,  di3,  di2,  di1,  di0};

  assign web = {web3, web2, web1, web0};

  always_ff @(posedge ck) begin
    if (cs) begin
      for (int b = 0; b < sram_be_w; b++) begin
        if (web[b] == sram_we_on) begin
          mem[addr][sram_byte_w*b +: sram_byte_w] <= din[sram_byte_w*b +: sram_byte_w];
        end
      end
      dout_q <= mem[addr];  // read before write
    end
  end

  assign dout = oe ? dout_q : {sram_data_w{1'bx}};  // floating outputs modeled as x

  assign {do31, do30, do29, do28, do27, do26, do25, do24,
          do23, do22, do21, do20, do19, do18, do17, do16,
          do15, do14, do13, do12, do11, do10, do9,  do8,
          do7,  do6,  do5,  do4,  do3,  do2,  do1,  do0} = dout;

endmodule

//--- verilog/sram_pkg.sv
package sram_pkg;

  // 16K x 32 macro
  localparam int sram_addr_w = 14;
  localparam int sram_data_w = 32;
  localparam int sram_be_w   = 4;
  localparam int sram_byte_w = sram_data_w / sram_be_w;
  localparam int sram_depth  = 1 << sram_addr_w;

  // byte write enables are active low
  localparam logic                 sram_we_on   = 1'b0;
  localparam logic [sram_be_w-1:0] sram_web_off = '1;

  localparam int sram_off_w    = 2;  // byte offset inside a word
  localparam int sram_region_w = 32 - sram_addr_w - sram_off_w;

  typedef struct packed {
    logic [sram_region_w-1:0] region;  // nonzero means outside the 64 KB window
    logic [sram_addr_w-1:0]   index;
    logic [sram_off_w-1:0]    offset;
  } sram_addr_s;

  // bus byte address seen either raw or split into fields
  typedef union packed {
    logic [31:0] raw;
    sram_addr_s  f;
  } sram_addr_u;

endpackage

//--- verilog/sram_wrapper.sv
`timescale 1ns/1ps

module sram_wrapper
  import sram_pkg::*;
(
  input  logic                   clk,
  input  logic [sram_addr_w-1:0] addr,
  input  logic [sram_data_w-1:0] wdata,
  input  logic [sram_be_w-1:0]   web,
  output logic [sram_data_w-1:0] rdata
);

  logic ck;
  logic cs;
  logic oe;

  assign ck = clk;
  assign cs = 1'b1;  // always selected
  assign oe = 1'b1;

  // one pin per bit on the macro side
  sram_macro sram_macro_i (
    .ck   (ck       ),
    .cs   (cs       ),
    .oe   (oe       ),
    .a0   (addr[0]  ),
    .a1   (addr[1]  ),
    .a2   (addr[2]  ),
    .a3   (addr[3]  ),
    .a4   (addr[4]  ),
    .a5   (addr[5]  ),
    .a6   (addr[6]  ),
    .a7   (addr[7]  ),
    .a8   (addr[8]  ),
    .a9   (addr[9]  ),
    .a10  (addr[10] ),
    .a11  (addr[11] ),
    .a12  (addr[12] ),
    .a13  (addr[13] ),
    .di0  (wdata[0] ),
    .di1  (wdata[1] ),
    .di2  (wdata[2] ),
    .di3  (wdata[3] ),
    .di4  (wdata[4] ),
    .di5  (wdata[5] ),
    .di6  (wdata[6] ),
    .di7  (wdata[7] ),
    .di8  (wdata[8] ),
    .di9  (wdata[9] ),
    .di10 (wdata[10]),
    .di11 (wdata[11]),
    .di12 (wdata[12]),
    .di13 (wdata[13]),
    .di14 (wdata[14]),
    .di15 (wdata[15]),
    .di16 (wdata[16]),
    .di17 (wdata[17]),
    .di18 (wdata[18]),
    .di19 (wdata[19]),
    .di20 (wdata[20]),
    .di21 (wdata[21]),
    .di22 (wdata[22]),
    .di23 (wdata[23]),
    .di24 (wdata[24]),
    .di25 (wdata[25]),
    .di26 (wdata[26]),
    .di27 (wdata[27]),
    .di28 (wdata[28]),
    .di29 (wdata[29]),
    .di30 (wdata[30]),
    .di31 (wdata[31]),
    .web0 (web[0]   ),
    .web1 (web[1]   ),
    .web2 (web[2]   ),
    .web3 (web[3]   ),
    .do0  (rdata[0] ),
    .do1  (rdata[1] ),
    .do2  (rdata[2] ),
    .do3  (rdata[3] ),
    .do4  (rdata[4] ),
    .do5  (rdata[5] ),
    .do6  (rdata[6] ),
    .do7  (rdata[7] ),
    .do8  (rdata[8] ),
    .do9  (rdata[9] ),
    .do10 (rdata[10]),
    .do11 (rdata[11]),
    .do12 (rdata[12]),
    .do13 (rdata[13]),
    .do14 (rdata[14]),
    .do15 (rdata[15]),
    .do16 (rdata[16]),
    .do17 (rdata[17]),
    .do18 (rdata[18]),
    .do19 (rdata[19]),
    .do20 (rdata[20]),
    .do21 (rdata[21]),
    .do22 (rdata[22]),
    .do23 (rdata[23]),
    .do24 (rdata[24]),
    .do25 (rdata[25]),
    .do26 (rdata[26]),
    .do27 (rdata[27]),
    .do28 (rdata[28]),
    .do29 (rdata[29]),
    .do30 (rdata[30]),
    .do31 (rdata[31])
  );

endmodule
